//--- include/vic_settings.svh
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// bus cycle shape, counted in color clock ticks
`define VIC_PHASES          16      // ticks per cpu bus cycle
`define VIC_PHI_RISE        8       // phi goes high here, vic owns the low half
`define VIC_SAMPLE_PHASE    12      // cpu access is latched at the end of this tick

// cpu visible color registers
// the window starts at the border register and runs through the sprite colors
`define VIC_COLOR_BASE      6'h20   // first color register
`define VIC_COLOR_COUNT     15      // border, 4 backgrounds, 2 mc, 8 sprites

// dram refresh
// counter runs downwards, one row per bus cycle
`define VIC_REFRESH_INIT    8'hff   // row after reset
`define VIC_REFRESH_HIGH    4'hf    // upper address nibble during refresh

// carrier offset so chroma idles at mid scale
`define VIC_CHROMA_MID      6'd32

`endif

//--- hw/vic_pkg.sv
`include "vic_settings.svh"

package vic_pkg;

    typedef struct packed {
        logic [3:0] phase;              // tick within the bus cycle
        logic       phi;                // cpu clock, high in the second half
        logic       cpu_sample;         // one tick strobe, cpu access latch point
    } cycle_t;

    typedef struct packed {
        logic       ce;                 // chip enable, low active
        logic       rw;                 // high = cpu read
        logic [5:0] addr;               // register number
        logic [7:0] data;               // cpu write data
    } cpu_bus_t;

    typedef struct packed {
        logic [11:0] ado;               // address out, adh + adl
        logic [7:0]  dbo;               // data out
        logic        write_ab;          // vic drives the address bus
        logic        write_db;          // vic drives the data bus
        logic        ras;               // row strobe, low active
        logic        cas;               // column strobe, low active
    } mem_bus_t;

    typedef struct packed {
        logic [5:0] luma;               // luma dac level
        logic [5:0] chroma;             // chroma dac level, 32 is no color
        logic       luma_sink;          // pull luma to sync/black level
    } video_t;

    typedef logic [`VIC_COLOR_COUNT-1:0][3:0] color_bank_t;    // 15 nibbles

    // luma level per color index, black .. light grey
    localparam logic [5:0] luma_table [16] = '{
        6'h00, 6'h3f, 6'h1a, 6'h2c, 6'h1e, 6'h26, 6'h16, 6'h33,
        6'h1e, 6'h16, 6'h26, 6'h1a, 6'h24, 6'h33, 6'h24, 6'h2c};
    // carrier phase offset, 22.5 degree steps
    localparam logic [3:0] hue_table [16] = '{
        4'd0, 4'd0, 4'd5, 4'd13, 4'd3, 4'd10, 4'd0, 4'd8,
        4'd6, 4'd7, 4'd5, 4'd0, 4'd0, 4'd10, 4'd0, 4'd0};
    // saturation, zero for the greys
    localparam logic [1:0] amp_table [16] = '{
        2'd0, 2'd0, 2'd3, 2'd3, 2'd3, 2'd2, 2'd3, 2'd2,
        2'd2, 2'd2, 2'd2, 2'd0, 2'd0, 2'd2, 2'd2, 2'd0};
    // one carrier period, peak 10 so 3 * 10 stays inside 6 bits around 32
    localparam logic signed [4:0] sine_table [16] = '{
        5'sd0, 5'sd4, 5'sd7, 5'sd9, 5'sd10, 5'sd9, 5'sd7, 5'sd4,
        5'sd0, -5'sd4, -5'sd7, -5'sd9, -5'sd10, -5'sd9, -5'sd7, -5'sd4};

endpackage

//--- hw/bus_cycle.sv
`timescale 1ns/1ps

`include "vic_settings.svh"

module bus_cycle (
    input  logic              clk_col16x_ntsc,  // 16x color clock
    input  logic              rst_n,
    output vic_pkg::cycle_t   cycle,            // phase, phi, sample strobe
    output vic_pkg::mem_bus_t refresh           // refresh address and strobes
);

    localparam logic [3:0] LAST_PHASE = 4'(`VIC_PHASES - 1);
    localparam logic [3:0] RAS_FALL   = 4'd4;   // ras low for the back half of phi low

    logic [3:0] phase;          // tick counter
    logic [3:0] phase_nxt;
    logic       phi_q;          // decodes registered from the next phase
    logic       sample_q;
    logic       ab_q;           // address bus owned by vic
    logic       ras_q;
    logic [7:0] refresh_cnt;    // dram row, counts down

    always_comb
    begin
        if (phase == LAST_PHASE)
            phase_nxt = 4'd0;   // wrap into a new bus cycle
        else
            phase_nxt = phase + 4'd1;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            phase    <= 4'd0;
            phi_q    <= 1'b0;
            sample_q <= 1'b0;
            ab_q     <= 1'b0;   // keep off the bus in reset
            ras_q    <= 1'b1;
        end
        else
        begin
            phase    <= phase_nxt;
            phi_q    <= (phase_nxt >= 4'(`VIC_PHI_RISE));   // second half of cycle
            sample_q <= (phase_nxt == 4'(`VIC_SAMPLE_PHASE));
            ab_q     <= (phase_nxt < 4'(`VIC_PHI_RISE));    // vic half
            ras_q    <= !((phase_nxt >= RAS_FALL) && (phase_nxt < 4'(`VIC_PHI_RISE)));
        end
    end

    // one row per bus cycle, steps after the last tick
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
            refresh_cnt <= `VIC_REFRESH_INIT;
        else if (phase == LAST_PHASE)
            refresh_cnt <= refresh_cnt - 8'd1;  // wraps 00 -> ff
    end

    assign cycle = '{phase: phase, phi: phi_q, cpu_sample: sample_q};

    // ras only refresh, cas parked high, data side belongs to color_regs
    assign refresh = '{ado: {`VIC_REFRESH_HIGH, refresh_cnt}, dbo: 8'h00,
                       write_ab: ab_q, write_db: 1'b0, ras: ras_q, cas: 1'b1};

endmodule

//--- hw/color_regs.sv
`timescale 1ns/1ps

`include "vic_settings.svh"

module color_regs (
    input  logic              clk_col16x_ntsc,  // 16x color clock
    input  logic              rst_n,
    input  vic_pkg::cycle_t   cycle,            // phi and sample strobe used
    input  vic_pkg::cpu_bus_t cpu,              // cpu register access
    output logic [7:0]        dbo,              // read data toward the pins
    output logic              write_db,         // vic drives the data bus
    output logic [3:0]        border            // border color index
);

    vic_pkg::color_bank_t bank;     // $20..$2e, one nibble each
    logic [5:0] offset;             // register number relative to the window
    logic [3:0] index;
    logic       hit;                // address falls in the color window
    logic       selected;           // chip enabled
    logic       cpu_write;

    assign offset = cpu.addr - `VIC_COLOR_BASE;
    assign index  = offset[3:0];
    // addresses below the base wrap to large offsets, one compare covers both ends
    assign hit = (offset < 6'(`VIC_COLOR_COUNT));

    assign selected  = !cpu.ce;
    assign cpu_write = cycle.cpu_sample && selected && !cpu.rw && hit;

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
            bank <= '0;                             // all black
        else if (cpu_write)
            bank[index] <= cpu.data[3:0];           // upper nibble not stored
    end

    // drive the bus only for a cpu read in phi high
    assign write_db = cycle.phi && selected && cpu.rw;

    always_comb
    begin
        if (hit)
            dbo = {4'hf, bank[index]};              // unused bits read as ones
        else
            dbo = 8'hff;                            // open bus outside the window
    end

    assign border = bank[0];    // $20 is the border register

endmodule

//--- hw/color_encoder.sv
`timescale 1ns/1ps

`include "vic_settings.svh"

module color_encoder (
    input  logic             clk_col16x_ntsc,   // 16x color clock, one carrier step per tick
    input  logic             rst_n,
    input  vic_pkg::cycle_t  cycle,             // phase is the carrier phase
    input  logic [3:0]       border,            // color index to show
    output vic_pkg::video_t  video              // registered dac levels
);

    logic [5:0]        luma_lvl;       // table lookups for the border color
    logic [3:0]        hue;
    logic [1:0]        amp;
    logic [3:0]        carrier;        // shifted carrier phase, wraps mod 16
    logic signed [4:0] sample;
    logic signed [7:0] scaled;         // amp * sine, max +-30
    logic signed [7:0] level;          // offset to mid scale

    always_comb
    begin
        luma_lvl = vic_pkg::luma_table[border];
        hue      = vic_pkg::hue_table[border];
        amp      = vic_pkg::amp_table[border];
        carrier  = cycle.phase + hue;                   // 4 bit add wraps the period
        sample   = vic_pkg::sine_table[carrier];
        scaled   = $signed({1'b0, amp}) * sample;       // greys give zero
        level    = $signed({2'b00, `VIC_CHROMA_MID}) + scaled;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            // come out of reset showing black
            video.luma      <= vic_pkg::luma_table[0];
            video.chroma    <= `VIC_CHROMA_MID;
            video.luma_sink <= (vic_pkg::luma_table[0] == 6'd0);
        end
        else
        begin
            video.luma      <= luma_lvl;
            video.chroma    <= level[5:0];              // always 2..62
            video.luma_sink <= (luma_lvl == 6'd0);      // sink on full black
        end
    end

endmodule

//--- hw/vic_pads.sv
`timescale 1ns/1ps

module vic_pads (
    input  logic [5:0]        adl_in,           // low address pins in
    output logic [5:0]        adl_out,          // low address pins out
    output logic [5:0]        adl_oe,           // per pin enable
    output logic [5:0]        adh,              // high address, always driven
    input  logic [7:0]        dbl_in,           // data pins in
    input  logic [3:0]        dbh,              // color ram nibble, no fetches yet
    output logic [7:0]        dbl_out,          // data pins out
    output logic [7:0]        dbl_oe,           // per pin enable
    input  logic              ce,               // chip enable, low active
    input  logic              rw,               // high = read
    output logic              ls245_addr_dir,   // address transceiver direction
    output logic              ls245_data_dir,   // data transceiver direction
    output logic              ls245_addr_oe,    // address transceiver enable, low active
    output logic              ls245_data_oe,    // data transceiver enable, low active
    output vic_pkg::cpu_bus_t cpu,              // cpu side to the register bank
    input  vic_pkg::mem_bus_t refresh,          // refresh address and ownership
    input  logic [7:0]        dbo,              // register read data
    input  logic              write_db          // register bank drives data
);

    // cpu sees the registers through the low address pins
    assign cpu = '{ce: ce, rw: rw, addr: adl_in, data: dbl_in};

    // 12 bit address split over the two pin groups
    assign adh     = refresh.ado[11:6];
    assign adl_out = refresh.ado[5:0];
    assign adl_oe  = {6{refresh.write_ab}};    // one enable fans out to every pin

    assign dbl_out = dbo;                      // cpu read data
    assign dbl_oe  = {8{write_db}};

    // transceivers point outward while vic owns the bus
    assign ls245_addr_dir = refresh.write_ab;
    assign ls245_data_dir = write_db;

    // transceivers stay enabled, direction does the work
    assign ls245_addr_oe = 1'b0;
    assign ls245_data_oe = 1'b0;

endmodule

//--- hw/vic_top.sv
`timescale 1ns/1ps

module vic_top (
    input  logic       clk_col16x_ntsc,     // 16x ntsc color clock
    input  logic       rst_n,
    input  logic [5:0] adl_in,              // address low in
    output logic [5:0] adl_out,             // address low out
    output logic [5:0] adl_oe,
    output logic [5:0] adh,                 // address high
    input  logic [7:0] dbl_in,              // data in
    input  logic [3:0] dbh,                 // color ram data
    output logic [7:0] dbl_out,             // data out
    output logic [7:0] dbl_oe,
    input  logic       ce,                  // chip enable, low active
    input  logic       rw,                  // high = read
    output logic       ls245_addr_dir,
    output logic       ls245_data_dir,
    output logic       ls245_addr_oe,
    output logic       ls245_data_oe,
    output logic       clk_phi,             // cpu clock
    output logic       aec,                 // address enable control
    output logic       ba,                  // bus available, never pulled
    output logic       irq,                 // open drain style, idle high
    output logic       ras,                 // dram row strobe
    output logic       cas,                 // dram column strobe
    output logic [5:0] luma,                // composite luma dac
    output logic [5:0] chroma,              // composite chroma dac
    output logic       luma_sink
);

    vic_pkg::cycle_t   cycle;       // phase and phi to everyone
    vic_pkg::mem_bus_t refresh;     // refresh address path
    vic_pkg::cpu_bus_t cpu;         // pins to registers
    vic_pkg::video_t   video;
    logic [7:0]        dbo;
    logic              write_db;
    logic [3:0]        border;

    bus_cycle u_bus_cycle (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .cycle           (cycle),
        .refresh         (refresh)
    );

    color_regs u_color_regs (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .cycle           (cycle),
        .cpu             (cpu),
        .dbo             (dbo),
        .write_db        (write_db),
        .border          (border)
    );

    color_encoder u_color_encoder (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .cycle           (cycle),
        .border          (border),
        .video           (video)
    );

    vic_pads u_vic_pads (
        .adl_in         (adl_in),
        .adl_out        (adl_out),
        .adl_oe         (adl_oe),
        .adh            (adh),
        .dbl_in         (dbl_in),
        .dbh            (dbh),
        .dbl_out        (dbl_out),
        .dbl_oe         (dbl_oe),
        .ce             (ce),
        .rw             (rw),
        .ls245_addr_dir (ls245_addr_dir),
        .ls245_data_dir (ls245_data_dir),
        .ls245_addr_oe  (ls245_addr_oe),
        .ls245_data_oe  (ls245_data_oe),
        .cpu            (cpu),
        .refresh        (refresh),
        .dbo            (dbo),
        .write_db       (write_db)
    );

    assign clk_phi = cycle.phi;
    assign aec     = cycle.phi;     // cpu owns the address bus in phi high
    assign ba      = 1'b1;          // no bad lines without fetches
    assign irq     = 1'b1;
    assign ras     = refresh.ras;
    assign cas     = refresh.cas;

    assign luma      = video.luma;
    assign chroma    = video.chroma;
    assign luma_sink = video.luma_sink;

endmodule

//--- tests/tb_vic_top.sv
`timescale 1ns/1ps

`include "vic_settings.svh"

module tb_vic_top;

    localparam int TEST_CYCLES   = 1 + 300 + 60 * 2 + 20 * 2 + `VIC_COLOR_COUNT + 16 * 3;
    localparam int TIMEOUT_TICKS = TEST_CYCLES * 16 + 200;     // ticks before giving up

    logic clk_col16x_ntsc = 1'b0;
    logic rst_n, ce, rw;
    logic [5:0] adl_in, adl_out, adl_oe, adh;
    logic [7:0] dbl_in, dbl_out, dbl_oe;
    logic [3:0] dbh;
    logic ls245_addr_dir, ls245_data_dir, ls245_addr_oe, ls245_data_oe;
    logic clk_phi, aec, ba, irq, ras, cas, luma_sink;
    logic [5:0] luma, chroma;
    vic_pkg::video_t video_pins;        // dac pins regrouped for compares

    logic [3:0] tb_phase;               // expected phase within the bus cycle
    int         run_ticks;              // ticks since reset release
    int         ticks = 0;              // all ticks counted for the timeout
    logic [7:0] exp_count;              // expected refresh row
    vic_pkg::video_t exp_video;         // one tick behind like the encoder
    logic [3:0] model_bank [`VIC_COLOR_COUNT];
    logic       exp_phi, exp_ab, exp_ras, exp_db;
    logic [31:0] lcg_state;
    string      test_name;
    logic [5:0] addr;
    logic [7:0] data, rd;
    logic [3:0] color;

    vic_top u_dut (.*);

    assign video_pins = {luma, chroma, luma_sink};

    always #10 clk_col16x_ntsc = ~clk_col16x_ntsc;     // 50 MHz stand-in

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];        // middle bits since the low ones are weak
    endfunction

    function automatic logic in_window(input logic [5:0] a);
        return (a >= `VIC_COLOR_BASE) && (a < `VIC_COLOR_BASE + `VIC_COLOR_COUNT);
    endfunction

    function automatic logic [7:0] ref_read(input logic [5:0] a);
        if (in_window(a))
            return {4'hf, model_bank[a - `VIC_COLOR_BASE]};    // upper nibble reads ones
        return 8'hff;                                           // nothing mapped there
    endfunction

    function automatic logic [11:0] ref_refresh(input logic [7:0] count);
        return 12'hf00 + {4'h0, count};
    endfunction

    function automatic vic_pkg::video_t ref_video(input logic [3:0] c, input logic [3:0] p);
        vic_pkg::video_t v;
        logic [3:0] step;
        int wave;
        int amp;
        step        = p + vic_pkg::hue_table[c];     // carrier wraps every 16 ticks
        wave        = vic_pkg::sine_table[step];
        amp         = vic_pkg::amp_table[c];
        v.luma      = vic_pkg::luma_table[c];
        v.chroma    = 6'(32 + amp * wave);          // mid scale plus scaled carrier
        v.luma_sink = (v.luma == 6'd0);
        return v;
    endfunction

    task automatic check_byte(input string what, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp)
        begin
            $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_address(input string what, input logic [11:0] act,
                                 input logic [11:0] exp);
        if (act !== exp)
        begin
            $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_video(input string what, input vic_pkg::video_t act,
                               input vic_pkg::video_t exp);
        if (act !== exp)
        begin
            $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // reference model stepping on the same edge as the dut
    always @(posedge clk_col16x_ntsc)
    begin
        if (!rst_n)
        begin
            tb_phase  <= 4'd0;
            run_ticks <= 0;
            exp_count <= 8'hff;
            exp_video <= ref_video(4'd0, 4'd0);         // black after reset
            for (int i = 0; i < `VIC_COLOR_COUNT; i++)
                model_bank[i] <= 4'h0;
        end
        else
        begin
            tb_phase  <= tb_phase + 4'd1;
            run_ticks <= run_ticks + 1;
            if (tb_phase == 4'd15)
                exp_count <= exp_count - 8'd1;          // next row with wrap
            exp_video <= ref_video(model_bank[0], tb_phase);
            if (tb_phase == 4'(`VIC_SAMPLE_PHASE) && !ce && !rw && in_window(adl_in))
                model_bank[adl_in - `VIC_COLOR_BASE] <= dbl_in[3:0];
        end
    end

    always @(posedge clk_col16x_ntsc)
    begin
        ticks <= ticks + 1;
        if (ticks == TIMEOUT_TICKS)
        begin
            $display("run timed out after %0d clock ticks", ticks);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // pins checked mid period away from both edges
    always @(negedge clk_col16x_ntsc)
    begin
        if (ticks > 0)
        begin
            exp_phi = (tb_phase >= 4'(`VIC_PHI_RISE));
            exp_ab  = (run_ticks != 0) && !exp_phi;     // enable comes up one tick after reset
            exp_ras = !((tb_phase >= 4'd4) && (tb_phase < 4'(`VIC_PHI_RISE)));
            exp_db  = exp_phi && !ce && rw;
            check_byte("control pins",
                       {clk_phi, aec, ba, irq, ras, cas, ls245_addr_oe, ls245_data_oe},
                       {exp_phi, exp_phi, 1'b1, 1'b1, exp_ras, 1'b1, 1'b0, 1'b0});
            check_byte("address enable", {2'b00, adl_oe}, {2'b00, {6{exp_ab}}});
            check_byte("transceiver dir", {6'd0, ls245_addr_dir, ls245_data_dir},
                       {6'd0, exp_ab, exp_db});
            check_byte("data enable", dbl_oe, {8{exp_db}});
            if (exp_ab)
                check_address("refresh address", {adh, adl_out}, ref_refresh(exp_count));
            if (exp_db)
                check_byte("data out", dbl_out, ref_read(adl_in));
            check_video("video", video_pins, exp_video);
        end
    end

    task automatic next_tick();
        @(posedge clk_col16x_ntsc);
        #2;                             // drive after the edge
    endtask

    task automatic goto_phase(input logic [3:0] p);
        next_tick();
        while (tb_phase != p)
            next_tick();
    endtask

    task automatic cpu_write(input logic [5:0] a, input logic [7:0] d);
        goto_phase(4'(`VIC_PHI_RISE));
        ce     = 1'b0;
        rw     = 1'b0;
        adl_in = a;
        dbl_in = d;
        goto_phase(4'(`VIC_SAMPLE_PHASE + 1));      // sampled at the end of phase 12
        ce     = 1'b1;
        rw     = 1'b1;
    endtask

    task automatic cpu_read(input logic [5:0] a, output logic [7:0] d);
        goto_phase(4'(`VIC_PHI_RISE));
        ce     = 1'b0;
        rw     = 1'b1;
        adl_in = a;
        @(negedge clk_col16x_ntsc);
        d = dbl_out;
        check_byte("read enable", dbl_oe, 8'hff);
        goto_phase(4'd2);               // ce stays low into phi low so the bus must let go
        ce = 1'b1;
    endtask

    initial
    begin
        lcg_state = 32'd58;
        rst_n     = 1'b0;
        ce        = 1'b1;
        rw        = 1'b1;
        adl_in    = 6'd0;
        dbl_in    = 8'd0;
        dbh       = 4'd0;
        test_name = "reset";
        repeat (5)
            next_tick();
        rst_n = 1'b1;

        test_name = "refresh";          // monitor walks the row counter
        repeat (300 * 16)
            next_tick();

        test_name = "write read";
        for (int n = 0; n < 60; n++)
        begin
            addr = 6'(`VIC_COLOR_BASE + lcg_byte() % `VIC_COLOR_COUNT);
            data = lcg_byte();
            cpu_write(addr, data);
            cpu_read(addr, rd);
            check_byte("read back", rd, {4'hf, data[3:0]});
        end

        test_name = "unmapped";
        for (int n = 0; n < 20; n++)
        begin
            addr = 6'(lcg_byte());
            if (in_window(addr))
                addr = addr ^ 6'h10;    // moves into 0x30..0x3e
            data = lcg_byte();
            cpu_write(addr, data);
            cpu_read(addr, rd);
            check_byte("open read", rd, 8'hff);
        end
        for (int n = 0; n < `VIC_COLOR_COUNT; n++)
        begin
            addr = 6'(`VIC_COLOR_BASE + n);
            cpu_read(addr, rd);
            check_byte("color kept", rd, ref_read(addr));
        end

        test_name = "encoder";
        for (int c = 0; c < 16; c++)
        begin
            color = 4'(c);
            data  = lcg_byte();
            cpu_write(`VIC_COLOR_BASE, {data[7:4], color});     // junk in the upper nibble
            goto_phase(4'd1);           // border and phase both new at this tick
            repeat (32)
            begin
                @(negedge clk_col16x_ntsc);
                check_video("border video", video_pins, ref_video(color, tb_phase - 4'd1));
                if (vic_pkg::amp_table[color] == 2'd0)
                    check_byte("grey chroma", {2'b00, chroma}, 8'd32);
                next_tick();
            end
        end

        if (ticks < TIMEOUT_TICKS)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
hw/vic_pkg.sv
hw/bus_cycle.sv
hw/color_regs.sv
hw/color_encoder.sv
hw/vic_pads.sv
hw/vic_top.sv
tests/tb_vic_top.sv

//--- Bender.yml
package:
  name: vic_top

sources:
  - include_dirs:
      - include
    files:
      - hw/vic_pkg.sv
      - hw/bus_cycle.sv
      - hw/color_regs.sv
      - hw/color_encoder.sv
      - hw/vic_pads.sv
      - hw/vic_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_vic_top.sv
